//--- build.f
logic/ca_pkg.sv
logic/ca_tx_strb.sv
logic/ca_rx_strb_det.sv
logic/ca_lane_fifo.sv
logic/ca_rx_align.sv
logic/ca.sv
verification/ca_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the channel alignment testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the testbench fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f build.f \
   --top-module ca_tb \
   -o ca_tb_sim

./obj_dir/ca_tb_sim

//--- verification/ca_tb.sv
/*
 Testbench for the two-lane channel alignment block.
 Applies a table of rows, one test per row, in a loop. Each row drives a
 strobed stream into both receive lanes, with lane 1 delayed by the row's
 skew, and random words on the transmit side. Responses are compared with
 a reference model of the strobe and deskew rules.
*/
`timescale 1ns/1ps

module ca_tb
   import ca_pkg::*;
();

   localparam int W           = NUM_LANES * LANE_BITS;
   localparam int N_ROWS      = 6;
   localparam int ROW_CYC     = 60;
   localparam int IDLE_CYC    = 3;
   localparam int FIRST_STB   = 3;
   localparam int MAX_SKEW    = 20;
   localparam int WATCHDOG_NS = N_ROWS * 200 * 40;

   ////////////////////////////////////////
   // Stimulus and expected value table
   ////////////////////////////////////////

   string row_name [N_ROWS] = '{"skew0", "skew2_drop", "skew5", "skew20_ovf", "coding",
                                "skew0_upper"};
   int    row_skew [N_ROWS] = '{0, 2, 5, 20, 0, 0};
   bit    row_wd   [N_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
   int    row_idx  [N_ROWS] = '{20, 5, 39, 30, 20, 0};
   // Second bit_sel bit, negative when the code is one-hot
   int    row_idx2 [N_ROWS] = '{-1, -1, -1, -1, 33, -1};
   int    row_intv [N_ROWS] = '{8, 5, 6, 4, 8, 2};
   int    row_dly  [N_ROWS] = '{0, 3, 7, 2, 1, 1};
   bit    row_drop [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
   bit    exp_err  [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
   bit    exp_code [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
   bit    exp_pos  [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

   logic                 com_clk;
   logic                 rst_n;
   logic                 tx_online;
   logic                 rx_online;
   logic                 tx_stb_en;
   stb_cfg_t             cfg;
   logic [2:0]           rden_dly;
   fifo_thr_t            thr;
   logic [W-1:0]         tx_din;
   logic [W-1:0]         rx_din;
   logic [W-1:0]         tx_dout;
   logic [W-1:0]         rx_dout;
   logic                 align_done;
   logic                 align_err;
   logic                 tx_stb_pos_coding_err;
   logic                 rx_stb_pos_err;
   logic                 rx_stb_pos_coding_err;
   logic [NUM_LANES-1:0] fifo_full;
   logic [NUM_LANES-1:0] fifo_empty;

   int                   seed = 64;
   logic [W-1:0]         exp_tx;
   logic [LANE_BITS-1:0] words [ROW_CYC];
   // Lane 1 delay line, entry k is the source word k cycles ago
   logic [LANE_BITS-1:0] hist [MAX_SKEW+1];

   ca UUT (
      .com_clk               (com_clk),
      .rst_n                 (rst_n),
      .tx_online             (tx_online),
      .rx_online             (rx_online),
      .tx_stb_en             (tx_stb_en),
      .tx_cfg                (cfg),
      .rx_cfg                (cfg),
      .rden_dly              (rden_dly),
      .fifo_thr              (thr),
      .tx_din                (tx_din),
      .rx_din                (rx_din),
      .tx_dout               (tx_dout),
      .rx_dout               (rx_dout),
      .align_done            (align_done),
      .align_err             (align_err),
      .tx_stb_pos_coding_err (tx_stb_pos_coding_err),
      .rx_stb_pos_err        (rx_stb_pos_err),
      .rx_stb_pos_coding_err (rx_stb_pos_coding_err),
      .fifo_full             (fifo_full),
      .fifo_empty            (fifo_empty)
   );

   initial com_clk = 1'b0;
   always #20 com_clk = ~com_clk;

   task automatic check_val(string name, logic [W-1:0] expected, logic [W-1:0] actual);
      if (expected !== actual)
      begin
         $display("FAILED %s expected %0h actual %0h", name, expected, actual);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   function automatic logic [W-1:0] rand_wide();
      logic [159:0] r;
      r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
      return r[W-1:0];
   endfunction

   // Strobe schedule of the source stream, with one strobe removed on drop rows
   function automatic bit stb_at(int r, int c);
      if (c < FIRST_STB || ((c - FIRST_STB) % row_intv[r]) != 0)
         return 1'b0;
      return !(row_drop[r] && (c == FIRST_STB + 3 * row_intv[r]));
   endfunction

   // Cycle index in the low 16 bits, random payload above
   function automatic logic [LANE_BITS-1:0] make_word(int c, bit stb, int pos);
      logic [95:0]          r;
      logic [LANE_BITS-1:0] w;
      r        = {$random(seed), $random(seed), $random(seed)};
      w        = r[LANE_BITS-1:0];
      w[15:0]  = 16'(c);
      w[pos]   = stb;
      return w;
   endfunction

   function automatic logic [W-1:0] force_stb(logic [W-1:0] d, int pos, bit s);
      for (int l = 0; l < NUM_LANES; l++)
      begin
         d[l*LANE_BITS + pos] = s;
      end
      return d;
   endfunction

   task automatic go_idle(int n);
      repeat (n)
      begin
         @(posedge com_clk);
         #2;
         tx_online = 1'b0;
         rx_online = 1'b0;
         tx_stb_en = 1'b0;
         tx_din    = '0;
         rx_din    = '0;
         exp_tx    = '0;
      end
   endtask

   ////////////////////////////////////////
   // One table row
   ////////////////////////////////////////

   task automatic run_row(int r);
      int                   pos;
      int                   lane1_stb;
      int                   first_out;
      int                   out_idx;
      bit                   active;
      bit                   done_seen;
      bit                   full_seen;
      logic [LANE_BITS-1:0] w;
      logic [W-1:0]         tdin;
      pos       = (row_wd[r] ? HALF_BITS : 0) + row_idx[r];
      active    = !exp_code[r];
      lane1_stb = FIRST_STB + row_skew[r];
      first_out = -1;
      done_seen = 1'b0;
      full_seen = 1'b0;
      for (int k = 0; k <= MAX_SKEW; k++)
         hist[k] = '0;
      cfg.wd_sel  = row_wd[r];
      cfg.bit_sel = 40'd1 << row_idx[r];
      if (row_idx2[r] >= 0)
         cfg.bit_sel[row_idx2[r]] = 1'b1;
      cfg.intv    = 8'(row_intv[r]);
      rden_dly    = 3'(row_dly[r]);
      for (int t = 0; t < ROW_CYC; t++)
      begin
         @(posedge com_clk);
         #1;
         check_val({row_name[r], " tx_dout"}, exp_tx, tx_dout);
         check_val({row_name[r], " tx coding"}, W'(exp_code[r]), W'(tx_stb_pos_coding_err));
         check_val({row_name[r], " rx coding"}, W'(exp_code[r]), W'(rx_stb_pos_coding_err));
         if (active)
         begin
            done_seen = done_seen | align_done;
            full_seen = full_seen | fifo_full[0];
            if (first_out < 0 && rx_dout != '0)
            begin
               first_out = t;
               check_val({row_name[r], " first strobe cycle"},
                         W'(lane1_stb + 3 + row_dly[r]), W'(t));
            end
            // Both lanes carry the same source word once released
            if (first_out >= 0)
            begin
               out_idx = FIRST_STB + t - first_out;
               check_val({row_name[r], " rx lane 0"}, W'(words[out_idx]),
                         W'(rx_dout[0 +: LANE_BITS]));
               check_val({row_name[r], " rx lane 1"}, W'(words[out_idx]),
                         W'(rx_dout[LANE_BITS +: LANE_BITS]));
            end
         end
         #1;
         w        = make_word(t, stb_at(r, t), pos);
         words[t] = w;
         for (int k = MAX_SKEW; k > 0; k--)
            hist[k] = hist[k-1];
         hist[0]   = w;
         tdin      = rand_wide();
         tx_online = active;
         tx_stb_en = active;
         rx_online = active;
         tx_din    = tdin;
         rx_din    = {hist[row_skew[r]], w};
         exp_tx    = active ? force_stb(tdin, pos, (t % row_intv[r]) == 0) : '0;
      end
      check_val({row_name[r], " align_err"}, W'(exp_err[r]), W'(align_err));
      check_val({row_name[r], " rx_stb_pos_err"}, W'(exp_pos[r]), W'(rx_stb_pos_err));
      if (active)
      begin
         check_val({row_name[r], " align_done seen"}, W'(!exp_err[r]), W'(done_seen));
         check_val({row_name[r], " rx output seen"}, W'(!exp_err[r]), W'(first_out >= 0));
         if (exp_err[r])
            check_val({row_name[r], " fifo_full[0] seen"}, W'(1'b1), W'(full_seen));
      end
   endtask

   initial
   begin
      rst_n        = 1'b0;
      tx_online    = 1'b0;
      rx_online    = 1'b0;
      tx_stb_en    = 1'b0;
      cfg.wd_sel   = 1'b0;
      cfg.bit_sel  = 40'd1 << 20;
      cfg.intv     = 8'd8;
      rden_dly     = 3'd0;
      thr.full_val = 5'd12;
      thr.empty_val = 3'd1;
      tx_din       = '0;
      rx_din       = '0;
      exp_tx       = '0;
      repeat (2) @(posedge com_clk);
      #2 rst_n = 1'b1;
      @(posedge com_clk);
      #1;
      check_val("reset align_done", '0, W'(align_done));
      check_val("reset align_err", '0, W'(align_err));
      check_val("reset tx coding", '0, W'(tx_stb_pos_coding_err));
      check_val("reset rx pos_err", '0, W'(rx_stb_pos_err));
      check_val("reset rx coding", '0, W'(rx_stb_pos_coding_err));
      check_val("reset fifo_full", '0, W'(fifo_full));
      check_val("reset fifo_empty", W'(2'b11), W'(fifo_empty));
      check_val("reset tx_dout", '0, tx_dout);
      check_val("reset rx_dout", '0, rx_dout);
      #1;
      for (int r = 0; r < N_ROWS; r++)
      begin
         go_idle(IDLE_CYC);
         run_row(r);
      end
      go_idle(IDLE_CYC);
      $display("Test OK");
      $finish;
   end

   // Watchdog sized from the row count
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout, the run did not finish in the expected time");
      $display("Test FAILED");
      $fatal(1);
   end

endmodule

//--- logic/ca.sv
/*
 Two-lane channel alignment top level.
 Transmit side inserts alignment strobes; receive side detects them per
 lane, deskews each lane in its own FIFO and releases all lanes together
 through the alignment controller. Everything runs on com_clk.
*/
`timescale 1ns/1ps

module ca
   import ca_pkg::*;
(
   input  logic                           com_clk,
   input  logic                           rst_n,
   input  logic                           tx_online,
   input  logic                           rx_online,
   input  logic                           tx_stb_en,
   input  stb_cfg_t                       tx_cfg,
   input  stb_cfg_t                       rx_cfg,
   input  logic [2:0]                     rden_dly,
   input  fifo_thr_t                      fifo_thr,
   input  logic [NUM_LANES*LANE_BITS-1:0] tx_din,
   input  logic [NUM_LANES*LANE_BITS-1:0] rx_din,
   output logic [NUM_LANES*LANE_BITS-1:0] tx_dout,
   output logic [NUM_LANES*LANE_BITS-1:0] rx_dout,
   output logic                           align_done,
   output logic                           align_err,
   output logic                           tx_stb_pos_coding_err,
   output logic                           rx_stb_pos_err,
   output logic                           rx_stb_pos_coding_err,
   output logic [NUM_LANES-1:0]           fifo_full,
   output logic [NUM_LANES-1:0]           fifo_empty
);

   lane_word_t                     lane_w [NUM_LANES];
   logic [POS_W-1:0]               lane_stb_pos [NUM_LANES];
   logic [NUM_LANES-1:0]           lane_valid;
   logic [NUM_LANES-1:0]           pos_err;
   logic [NUM_LANES-1:0]           coding_err;
   logic [NUM_LANES-1:0]           overflow;
   logic [NUM_LANES*LANE_BITS-1:0] fifo_dout;
   logic                           rd_en;

   ca_tx_strb u_tx_strb (
      .com_clk    (com_clk),
      .rst_n      (rst_n),
      .tx_online  (tx_online),
      .tx_stb_en  (tx_stb_en),
      .cfg        (tx_cfg),
      .tx_din     (tx_din),
      .tx_dout    (tx_dout),
      .coding_err (tx_stb_pos_coding_err)
   );

   ////////////////////////////////////////
   // Per-lane detect and deskew
   ////////////////////////////////////////

   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      ca_rx_strb_det u_det (
         .com_clk    (com_clk),
         .rst_n      (rst_n),
         .rx_online  (rx_online),
         .cfg        (rx_cfg),
         .din        (rx_din[i*LANE_BITS +: LANE_BITS]),
         .lane       (lane_w[i]),
         .stb_hit    (),
         .pos_err    (pos_err[i]),
         .coding_err (coding_err[i]),
         .stb_pos    (lane_stb_pos[i])
      );

      ca_lane_fifo u_fifo (
         .com_clk  (com_clk),
         .rst_n    (rst_n),
         .lane     (lane_w[i]),
         .rd_en    (rd_en),
         .thr      (fifo_thr),
         .dout     (fifo_dout[i*LANE_BITS +: LANE_BITS]),
         .full     (fifo_full[i]),
         .empty    (fifo_empty[i]),
         .overflow (overflow[i])
      );

      assign lane_valid[i] = lane_w[i].valid;
   end

   assign rx_stb_pos_err        = |pos_err;
   assign rx_stb_pos_coding_err = |coding_err;

   // Lane 0 decode serves the controller
   ca_rx_align u_align (
      .com_clk    (com_clk),
      .rst_n      (rst_n),
      .rx_online  (rx_online),
      .lane_valid (lane_valid),
      .rden_dly   (rden_dly),
      .fifo_dout  (fifo_dout),
      .overflow   (overflow),
      .stb_pos    (lane_stb_pos[0]),
      .rd_en      (rd_en),
      .rx_dout    (rx_dout),
      .align_done (align_done),
      .align_err  (align_err)
   );

endmodule

//--- logic/ca_rx_align.sv
/*
 Receive alignment controller.
 Waits for every lane to see its first strobe, holds off for rden_dly
 cycles and then reads all deskew FIFOs together every cycle. The
 FIFO read registers feed rx_dout, which stays zero until read data is
 flowing. FIFO overflow or a strobe mismatch across lanes ends in
 AL_ERROR until rx_online drops.
*/
`timescale 1ns/1ps

module ca_rx_align
   import ca_pkg::*;
(
   input  logic                           com_clk,
   input  logic                           rst_n,
   input  logic                           rx_online,
   input  logic [NUM_LANES-1:0]           lane_valid,
   input  logic [2:0]                     rden_dly,
   input  logic [NUM_LANES*LANE_BITS-1:0] fifo_dout,
   input  logic [NUM_LANES-1:0]           overflow,
   input  logic [POS_W-1:0]               stb_pos,
   output logic                           rd_en,
   output logic [NUM_LANES*LANE_BITS-1:0] rx_dout,
   output logic                           align_done,
   output logic                           align_err
);

   align_state_t         state;
   align_state_t         state_nxt;
   logic [2:0]           dly_cnt;
   logic                 rd_vld;
   logic [NUM_LANES-1:0] stb_bits;
   logic                 stb_mismatch;

   // Strobe bit of each lane in the word currently on the read registers
   always_comb
   begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
         stb_bits[l] = fifo_dout[l*LANE_BITS + int'(stb_pos)];
      end
   end

   assign stb_mismatch = rd_vld && (|stb_bits) && !(&stb_bits);

   ////////////////////////////////////////
   // Alignment FSM
   ////////////////////////////////////////

   always_comb
   begin
      state_nxt = state;
      case (state)
         AL_IDLE:
            if (rx_online)
               state_nxt = AL_WAIT_LANES;
         AL_WAIT_LANES:
            if (&lane_valid)
               state_nxt = (rden_dly == 3'd0) ? AL_ALIGNED : AL_DELAY;
         AL_DELAY:
            if (dly_cnt == rden_dly - 3'd1)
               state_nxt = AL_ALIGNED;
         default:
            state_nxt = state;
      endcase
      if ((state != AL_IDLE) && (|overflow || stb_mismatch))
         state_nxt = AL_ERROR;
      // Going offline always restarts alignment
      if (!rx_online)
         state_nxt = AL_IDLE;
   end

   always_ff @(posedge com_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= AL_IDLE;
         dly_cnt <= 3'd0;
         rd_vld  <= 1'b0;
      end
      else
      begin
         state   <= state_nxt;
         dly_cnt <= (state == AL_DELAY) ? dly_cnt + 3'd1 : 3'd0;
         // Marks the cycle the FIFO read registers hold fresh data
         rd_vld  <= rd_en;
      end
   end

   assign rd_en      = (state == AL_ALIGNED);
   assign align_done = (state == AL_ALIGNED);
   assign align_err  = (state == AL_ERROR);
   assign rx_dout    = rd_vld ? fifo_dout : '0;

   a_rd_all_valid : assert property (@(posedge com_clk) disable iff (!rst_n)
      rd_en |-> (&lane_valid));

endmodule

//--- logic/ca_lane_fifo.sv
/*
 Deskew FIFO for one lane.
 Writes every cycle while the lane is started and reads on rd_en from
 the alignment controller, with the read word registered. Occupancy
 drives the programmable full and empty flags. The whole FIFO is
 flushed whenever the lane is not started.
*/
`timescale 1ns/1ps

module ca_lane_fifo
   import ca_pkg::*;
(
   input  logic                 com_clk,
   input  logic                 rst_n,
   input  lane_word_t           lane,
   input  logic                 rd_en,
   input  fifo_thr_t            thr,
   output logic [LANE_BITS-1:0] dout,
   output logic                 full,
   output logic                 empty,
   output logic                 overflow
);

   logic [LANE_BITS-1:0] mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0]   wr_ptr;
   logic [FIFO_AW-1:0]   rd_ptr;
   logic [FIFO_AW:0]     count;
   logic                 mem_full;
   logic                 do_rd;
   logic                 do_wr;

   assign mem_full = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign do_rd    = rd_en && (count != '0);
   // A read in the same cycle frees the slot for the incoming word
   assign do_wr    = lane.valid && (!mem_full || do_rd);
   assign overflow = lane.valid && mem_full && !do_rd;

   assign full  = (count >= thr.full_val);
   assign empty = (count <= {2'b00, thr.empty_val});

   ////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////

   always_ff @(posedge com_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (!lane.valid)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (FIFO_AW+1)'(do_wr) - (FIFO_AW+1)'(do_rd);
      end
   end

   ////////////////////////////////////////
   // Storage and read register
   ////////////////////////////////////////

   always_ff @(posedge com_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= lane.data;
   end

   always_ff @(posedge com_clk)
   begin
      if (do_rd)
         dout <= mem[rd_ptr];
   end

   // Controller must not start reading before this lane has data
   a_no_empty_rd : assert property (@(posedge com_clk) disable iff (!rst_n)
      rd_en |-> (count != '0));

endmodule

//--- logic/ca_rx_strb_det.sv
/*
 Receive strobe detector for one lane.
 Registers the incoming lane word, marks the lane as started from its
 first strobe on, and checks that later strobes keep the configured
 spacing. A spacing fault is held until rx_online drops.
*/
`timescale 1ns/1ps

module ca_rx_strb_det
   import ca_pkg::*;
(
   input  logic                 com_clk,
   input  logic                 rst_n,
   input  logic                 rx_online,
   input  stb_cfg_t             cfg,
   input  logic [LANE_BITS-1:0] din,
   output lane_word_t           lane,
   output logic                 stb_hit,
   output logic                 pos_err,
   output logic                 coding_err,
   output logic [POS_W-1:0]     stb_pos
);

   logic [LANE_BITS-1:0] data_q;
   logic                 valid_q;
   logic                 hit_in;
   logic                 armed;
   logic [7:0]           sp_cnt;
   logic                 expect_hit;

   assign stb_pos    = stb_pos_f(cfg);
   assign coding_err = !$onehot(cfg.bit_sel);
   assign hit_in     = rx_online && din[stb_pos];

   // Payload stage
   always_ff @(posedge com_clk)
   begin
      data_q <= din;
   end

   always_ff @(posedge com_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
         stb_hit <= 1'b0;
      end
      else
      begin
         valid_q <= rx_online && (valid_q || hit_in);
         stb_hit <= hit_in;
      end
   end

   assign lane = '{data: data_q, valid: valid_q};

   ////////////////////////////////////////
   // Spacing check
   ////////////////////////////////////////

   // Armed one cycle after the first hit
   // sp_cnt counts cycles since the last strobe
   assign expect_hit = armed && (sp_cnt == cfg.intv);

   always_ff @(posedge com_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         armed   <= 1'b0;
         sp_cnt  <= 8'd0;
         pos_err <= 1'b0;
      end
      else if (!rx_online)
      begin
         armed   <= 1'b0;
         sp_cnt  <= 8'd0;
         pos_err <= 1'b0;
      end
      else
      begin
         armed <= armed || stb_hit;
         // A missed strobe restarts the period as if it had arrived
         sp_cnt <= (stb_hit || expect_hit) ? 8'd1 : sp_cnt + 8'd1;
         if (armed && (stb_hit != expect_hit))
            pos_err <= 1'b1;
      end
   end

   // Spacing check needs at least two cycles between strobes
   a_rx_intv_min : assert property (@(posedge com_clk) disable iff (!rst_n)
      rx_online |-> (cfg.intv >= 8'd2));

endmodule

//--- logic/ca_tx_strb.sv
/*
 Transmit strobe insertion for all lanes.
 An interval counter runs while the link is online and the strobe is
 enabled; on its wrap cycle the strobe bit of every lane is forced high,
 otherwise it is forced low. Output is registered, one cycle latency.
*/
`timescale 1ns/1ps

module ca_tx_strb
   import ca_pkg::*;
(
   input  logic                           com_clk,
   input  logic                           rst_n,
   input  logic                           tx_online,
   input  logic                           tx_stb_en,
   input  stb_cfg_t                       cfg,
   input  logic [NUM_LANES*LANE_BITS-1:0] tx_din,
   output logic [NUM_LANES*LANE_BITS-1:0] tx_dout,
   output logic                           coding_err
);

   logic [POS_W-1:0]               stb_pos;
   logic [7:0]                     intv_cnt;
   logic                           run;
   logic                           wrap;
   logic [NUM_LANES*LANE_BITS-1:0] tx_next;

   assign stb_pos    = stb_pos_f(cfg);
   assign coding_err = !$onehot(cfg.bit_sel);

   ////////////////////////////////////////
   // Interval counter
   ////////////////////////////////////////

   assign run  = tx_online && tx_stb_en;
   // Counter sits at zero while idle, so the first enabled cycle strobes
   assign wrap = run && (intv_cnt == 8'd0);

   always_ff @(posedge com_clk or negedge rst_n)
   begin
      if (!rst_n)
         intv_cnt <= 8'd0;
      else if (!run)
         intv_cnt <= 8'd0;
      else if (intv_cnt == cfg.intv - 8'd1)
         intv_cnt <= 8'd0;
      else
         intv_cnt <= intv_cnt + 8'd1;
   end

   ////////////////////////////////////////
   // Strobe bit force and output register
   ////////////////////////////////////////

   always_comb
   begin
      tx_next = tx_din;
      for (int l = 0; l < NUM_LANES; l++)
      begin
         tx_next[l*LANE_BITS + int'(stb_pos)] = wrap;
      end
   end

   always_ff @(posedge com_clk or negedge rst_n)
   begin
      if (!rst_n)
         tx_dout <= '0;
      else if (tx_online)
         tx_dout <= tx_next;
      else
         tx_dout <= '0;
   end

   // Strobe spacing of one would leave no data cycles
   a_intv_min : assert property (@(posedge com_clk) disable iff (!rst_n)
      (tx_online && tx_stb_en) |-> (cfg.intv >= 8'd2));

endmodule

//--- logic/ca_pkg.sv
/*
 Shared definitions for the two-lane channel alignment block.
 Holds lane sizes, FIFO depth, the strobe and FIFO configuration
 structs, the alignment state enum and the strobe position decode.
 Modules pull these in with a wildcard import in their header.
*/
package ca_pkg;

   // Lane geometry
   localparam int NUM_LANES  = 2;
   localparam int LANE_BITS  = 80;
   localparam int HALF_BITS  = 40;
   localparam int POS_W      = 7;

   // Deskew FIFO geometry
   localparam int FIFO_AW    = 4;
   localparam int FIFO_DEPTH = 1 << FIFO_AW;

   // Strobe configuration, one per direction
   typedef struct packed {
      logic                 wd_sel;
      logic [HALF_BITS-1:0] bit_sel;
      logic [7:0]           intv;
   } stb_cfg_t;

   // Registered receive word of one lane
   typedef struct packed {
      logic [LANE_BITS-1:0] data;
      logic                 valid;
   } lane_word_t;

   // FIFO occupancy thresholds
   typedef struct packed {
      logic [FIFO_AW:0] full_val;
      logic [2:0]       empty_val;
   } fifo_thr_t;

   typedef enum logic [2:0] {
      AL_IDLE,
      AL_WAIT_LANES,
      AL_DELAY,
      AL_ALIGNED,
      AL_ERROR
   } align_state_t;

   // Bit index of the strobe, lowest set bit wins on a bad code
   function automatic logic [POS_W-1:0] stb_pos_f(stb_cfg_t cfg);
      logic [POS_W-1:0] idx;
      idx = '0;
      for (int b = HALF_BITS - 1; b >= 0; b--)
      begin
         if (cfg.bit_sel[b])
            idx = POS_W'(b);
      end
      return cfg.wd_sel ? idx + POS_W'(HALF_BITS) : idx;
   endfunction

endpackage
